/* hw/hartnn_pkg.sv */
package hartnn_pkg;

    // network sizes, the fixed weights in hartnn only fit these values
    localparam int N_FEAT  = 12;
    localparam int FEAT_W  = 4;
    localparam int N_HID   = 40;
    localparam int N_CLASS = 6;
    localparam int CLASS_W = $clog2(N_CLASS);

    // wishbone classic slave, word addressed
    localparam int WB_DW = 32;
    localparam int WB_AW = 3;

    typedef enum logic [2:0] {
        REG_FEAT_LO = 3'd0,  // features 0 to 7, feature k in bits 4k+3:4k
        REG_FEAT_HI = 3'd1,  // features 8 to 11 in the low half
        REG_CTRL    = 3'd2,  // bit 0 starts a classification
        REG_STATUS  = 3'd3,  // bit 0 busy, bit 1 done
        REG_RESULT  = 3'd4   // class index of the last sample
    } reg_addr_e;

    // one sample at a time, busy covers ST_SNAP and ST_LATCH
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SNAP,
        ST_LATCH
    } ctrl_state_e;

endpackage

/* hw/argmax.sv */
`timescale 1ns/1ps

module argmax #(
    parameter int N = hartnn_pkg::N_CLASS,
    parameter int I = hartnn_pkg::CLASS_W,
    parameter int K = $clog2(hartnn_pkg::N_HID + 1)
) (
    input  logic [N*K-1:0] inx,
    output logic [I-1:0]   outimax
);

    logic [K-1:0] best;

    // score 0 sits in the low slice of inx
    always_comb begin
        best    = inx[K-1:0];
        outimax = '0;
        for (int j = 1; j < N; j++) begin
            // strictly greater, so an equal score later on never wins
            if (inx[j*K +: K] > best) begin
                best    = inx[j*K +: K];
                outimax = I'(j);
            end
        end
    end

endmodule

/* hw/feature_bank.sv */
`timescale 1ns/1ps

module feature_bank #(
    parameter int N = hartnn_pkg::N_FEAT,
    parameter int B = hartnn_pkg::FEAT_W
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         we_lo,
    input  logic                         we_hi,
    input  logic [hartnn_pkg::WB_DW-1:0] wdata,
    input  logic                         snap,
    output logic [N*B-1:0]               feat_vec
);

    import hartnn_pkg::*;

    localparam int PER_WORD = WB_DW / B;  // nibbles held by one bus word

    logic [N*B-1:0] bank;  // live features, already in network slot order

    for (genvar k = 0; k < N; k++) begin : g_feat
        localparam int WORD = k / PER_WORD;
        localparam int LANE = k % PER_WORD;

        logic       we;
        logic [B-1:0] nib_q;

        assign we = (WORD == 0) ? we_lo : we_hi;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                nib_q <= '0;
            end else if (we) begin
                nib_q <= wdata[LANE*B +: B];
            end
        end

        // the network numbers its inputs from the top slot down
        assign bank[(N-1-k)*B +: B] = nib_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            feat_vec <= '0;
        end else if (snap) begin
            feat_vec <= bank;  // frozen until the next start
        end
    end

endmodule

/* hw/hartnn.sv */
`timescale 1ns/1ps

module hartnn #(
    parameter int N  = hartnn_pkg::N_FEAT,
    parameter int B  = hartnn_pkg::FEAT_W,
    parameter int M  = hartnn_pkg::N_HID,
    parameter int C  = hartnn_pkg::N_CLASS,
    parameter int Ts = 5  // training threshold, carried in the parameter list only
) (
    input  logic [N*B-1:0]                 inp,
    output logic [hartnn_pkg::CLASS_W-1:0] klass
);

    import hartnn_pkg::*;

    localparam int SUM_W   = $clog2(N + 1) + B;  // room for N full-scale features
    localparam int SCORE_W = $clog2(M + 1);
    localparam int TIE_LO  = 2;
    localparam int TIE_HI  = 5;

    // per neuron {positive set, negative set}, bit k of each set is feature k
    localparam logic [2*N-1:0] HID_W [M] = '{
        24'hD42_299, 24'h32A_084,
        24'h000_000, 24'h00C_A31,
        24'h1C8_E00, 24'h000_000,
        24'hA0C_102, 24'h946_2B9,
        24'h020_40E, 24'hA23_4CC,
        24'h308_036, 24'h08C_C00,
        24'hAF0_001, 24'h483_A28,
        24'h4C5_008, 24'h00A_C21,
        24'h109_E00, 24'h101_A42,
        24'hA28_101, 24'hD61_08E,
        24'hB10_402, 24'h0C0_208,
        24'h420_390, 24'hC84_211,
        24'hAC8_102, 24'h25A_885,
        24'h444_09A, 24'h20A_050,
        24'h0A0_B01, 24'h059_886,
        24'h109_206, 24'h10B_0F0,
        24'h006_E38, 24'h0D2_82D,
        24'hC92_049, 24'h612_941,
        24'h00A_431, 24'h0C0_225,
        24'h110_801, 24'h489_B10
    };

    // hidden bits counted by each class
    localparam logic [M-1:0] OUT_USE [C] = '{
        40'h15_5753_6440,
        40'h1E_A155_5C60,
        40'h03_0F66_2443,
        40'h45_A127_0813,
        40'h49_A204_5930,
        40'hC9_2C86_2809
    };

    // hidden bits that vote when they are low
    localparam logic [M-1:0] OUT_INV [C] = '{
        40'h11_5441_4000,
        40'h1A_A041_0820,
        40'h02_0460_2001,
        40'h40_2004_0802,
        40'h48_A204_0010,
        40'h48_2084_0000
    };

    logic [B-1:0]         feat [N];
    logic [M-1:0]         hid;
    logic [C*SCORE_W-1:0] scores;

    for (genvar k = 0; k < N; k++) begin : g_unpack
        assign feat[k] = inp[(N-1-k)*B +: B];
    end

    for (genvar h = 0; h < M; h++) begin : g_hid
        if (h == TIE_LO) begin : g_tie_lo
            assign hid[h] = 1'b0;
        end else if (h == TIE_HI) begin : g_tie_hi
            assign hid[h] = 1'b1;
        end else begin : g_neuron
            logic [SUM_W-1:0] pos_sum;
            logic [SUM_W-1:0] neg_sum;

            always_comb begin
                pos_sum = '0;
                neg_sum = '0;
                for (int k = 0; k < N; k++) begin
                    if (HID_W[h][N + k]) pos_sum = pos_sum + SUM_W'(feat[k]);
                    if (HID_W[h][k]) neg_sum = neg_sum + SUM_W'(feat[k]);
                end
            end

            assign hid[h] = (pos_sum >= neg_sum);  // fires on a tie too
        end
    end

    for (genvar c = 0; c < C; c++) begin : g_out
        logic [M-1:0]       votes;
        logic [SCORE_W-1:0] cnt;

        assign votes = (hid ^ OUT_INV[c]) & OUT_USE[c];

        always_comb begin
            cnt = '0;
            for (int h = 0; h < M; h++) begin
                cnt = cnt + SCORE_W'(votes[h]);
            end
        end

        assign scores[c*SCORE_W +: SCORE_W] = cnt;
    end

    argmax #(
        .N(C),
        .I(CLASS_W),
        .K(SCORE_W)
    ) u_argmax (
        .inx    (scores),
        .outimax(klass)
    );

endmodule

/* hw/hartnn_ctrl.sv */
`timescale 1ns/1ps

module hartnn_ctrl (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [hartnn_pkg::WB_AW-1:0]   wb_adr,
    input  logic [hartnn_pkg::WB_DW-1:0]   wb_dat_w,
    output logic [hartnn_pkg::WB_DW-1:0]   wb_dat_r,
    output logic                           wb_ack,
    output logic                           feat_we_lo,
    output logic                           feat_we_hi,
    output logic [hartnn_pkg::WB_DW-1:0]   feat_wdata,
    output logic                           snap,
    input  logic [hartnn_pkg::CLASS_W-1:0] klass
);

    import hartnn_pkg::*;

    ctrl_state_e        state;
    reg_addr_e          adr_e;
    logic               req;
    logic               stall;
    logic               accept;
    logic               wr;
    logic               start;
    logic               busy;
    logic               done_q;
    logic [CLASS_W-1:0] result_q;

    assign adr_e = reg_addr_e'(wb_adr);
    assign req   = wb_cyc & wb_stb & ~wb_ack;  // new access, not the one being acked

    // a result read waits while the snapshot is loading
    // from ST_LATCH on it is acked the cycle after and sees the fresh result
    assign stall  = ~wb_we & (adr_e == REG_RESULT) & (state == ST_SNAP);
    assign accept = req & ~stall;
    assign wr     = accept & wb_we;

    assign feat_we_lo = wr & (adr_e == REG_FEAT_LO);
    assign feat_we_hi = wr & (adr_e == REG_FEAT_HI);
    assign feat_wdata = wb_dat_w;
    assign start      = wr & (adr_e == REG_CTRL) & wb_dat_w[0];

    assign busy = (state != ST_IDLE);
    assign snap = (state == ST_SNAP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            state    <= ST_IDLE;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            wb_ack <= accept;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state  <= ST_SNAP;
                        done_q <= 1'b0;
                    end
                end
                ST_SNAP: begin
                    state <= ST_LATCH;  // network settles on the new snapshot
                end
                ST_LATCH: begin
                    result_q <= klass;
                    done_q   <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // read data only has to be right while ack is high
    always_comb begin
        wb_dat_r = '0;
        case (adr_e)
            REG_STATUS: wb_dat_r[1:0] = {done_q, busy};
            REG_RESULT: wb_dat_r[CLASS_W-1:0] = result_q;
            default:    wb_dat_r = '0;  // features and control read as zero
        endcase
    end

    a_ack_single : assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    a_ack_in_cycle : assert property (@(posedge clk) disable iff (!arst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack outside of a bus cycle");

    // ST_SNAP is the ack cycle of the start that was accepted just before
    a_snap_start : assert property (@(posedge clk) disable iff (!arst_n)
        snap |-> wb_ack && $past(start))
        else $error("snap without an accepted start");

endmodule

/* hw/hartnn_wb_top.sv */
`timescale 1ns/1ps

module hartnn_wb_top #(
    parameter int N = hartnn_pkg::N_FEAT,
    parameter int B = hartnn_pkg::FEAT_W,
    parameter int M = hartnn_pkg::N_HID,
    parameter int C = hartnn_pkg::N_CLASS
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [hartnn_pkg::WB_AW-1:0] wb_adr,
    input  logic [hartnn_pkg::WB_DW-1:0] wb_dat_w,
    output logic [hartnn_pkg::WB_DW-1:0] wb_dat_r,
    output logic                         wb_ack
);

    import hartnn_pkg::*;

    logic               feat_we_lo;
    logic               feat_we_hi;
    logic [WB_DW-1:0]   feat_wdata;
    logic               snap;
    logic [N*B-1:0]     feat_vec;
    logic [CLASS_W-1:0] klass;

    hartnn_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .feat_we_lo(feat_we_lo),
        .feat_we_hi(feat_we_hi),
        .feat_wdata(feat_wdata),
        .snap      (snap),
        .klass     (klass)
    );

    feature_bank #(
        .N(N),
        .B(B)
    ) u_bank (
        .clk     (clk),
        .arst_n  (arst_n),
        .we_lo   (feat_we_lo),
        .we_hi   (feat_we_hi),
        .wdata   (feat_wdata),
        .snap    (snap),
        .feat_vec(feat_vec)
    );

    hartnn #(
        .N(N),
        .B(B),
        .M(M),
        .C(C)
    ) u_net (
        .inp  (feat_vec),
        .klass(klass)
    );

endmodule

/* sim/hartnn_ref.svh */
`ifndef HARTNN_REF_SVH
`define HARTNN_REF_SVH

// hidden neurons with a constant output, their weights are never used
localparam int REF_TIE_LO = 2;
localparam int REF_TIE_HI = 5;

// features summed on the positive side of each neuron, bit k is feature k
localparam logic [N_FEAT-1:0] REF_POS [N_HID] = '{
    12'hD42, 12'h32A, 12'h000, 12'h00C, 12'h1C8, 12'h000, 12'hA0C, 12'h946,
    12'h020, 12'hA23, 12'h308, 12'h08C, 12'hAF0, 12'h483, 12'h4C5, 12'h00A,
    12'h109, 12'h101, 12'hA28, 12'hD61, 12'hB10, 12'h0C0, 12'h420, 12'hC84,
    12'hAC8, 12'h25A, 12'h444, 12'h20A, 12'h0A0, 12'h059, 12'h109, 12'h10B,
    12'h006, 12'h0D2, 12'hC92, 12'h612, 12'h00A, 12'h0C0, 12'h110, 12'h489
};

// features summed on the negative side
localparam logic [N_FEAT-1:0] REF_NEG [N_HID] = '{
    12'h299, 12'h084, 12'h000, 12'hA31, 12'hE00, 12'h000, 12'h102, 12'h2B9,
    12'h40E, 12'h4CC, 12'h036, 12'hC00, 12'h001, 12'hA28, 12'h008, 12'hC21,
    12'hE00, 12'hA42, 12'h101, 12'h08E, 12'h402, 12'h208, 12'h390, 12'h211,
    12'h102, 12'h885, 12'h09A, 12'h050, 12'hB01, 12'h886, 12'h206, 12'h0F0,
    12'hE38, 12'h82D, 12'h049, 12'h941, 12'h431, 12'h225, 12'h801, 12'hB10
};

// hidden bits that each class counts
localparam logic [N_HID-1:0] REF_USE [N_CLASS] = '{
    40'h15_5753_6440, 40'h1E_A155_5C60, 40'h03_0F66_2443,
    40'h45_A127_0813, 40'h49_A204_5930, 40'hC9_2C86_2809
};

// of those, the bits that count when they are low
localparam logic [N_HID-1:0] REF_INV [N_CLASS] = '{
    40'h11_5441_4000, 40'h1A_A041_0820, 40'h02_0460_2001,
    40'h40_2004_0802, 40'h48_A204_0010, 40'h48_2084_0000
};

// feats holds feature k in bits 4k+3:4k, the same order as the register map
function automatic logic [CLASS_W-1:0] ref_class(input logic [N_FEAT*FEAT_W-1:0] feats);
    logic [N_HID-1:0]   hid;
    int                 pos;
    int                 neg;
    int                 score;
    int                 best;
    logic [CLASS_W-1:0] win;

    hid = '0;
    for (int h = 0; h < N_HID; h++) begin
        pos = 0;
        neg = 0;
        for (int k = 0; k < N_FEAT; k++) begin
            if (REF_POS[h][k]) pos += int'(feats[k*FEAT_W +: FEAT_W]);
            if (REF_NEG[h][k]) neg += int'(feats[k*FEAT_W +: FEAT_W]);
        end
        hid[h] = (pos >= neg);  // a tie fires the neuron
    end
    hid[REF_TIE_LO] = 1'b0;
    hid[REF_TIE_HI] = 1'b1;

    best = -1;
    win  = '0;
    for (int c = 0; c < N_CLASS; c++) begin
        score = 0;
        for (int h = 0; h < N_HID; h++) begin
            if (REF_USE[c][h] && (hid[h] != REF_INV[c][h])) score++;
        end
        if (score > best) begin  // lower index keeps a tie
            best = score;
            win  = CLASS_W'(c);
        end
    end
    return win;
endfunction

`endif

/* sim/tb_hartnn_wb.sv */
`timescale 1ns/1ps

module tb_hartnn_wb;

    import hartnn_pkg::*;

    `include "hartnn_ref.svh"

    localparam int NUM_RAND  = 200;
    localparam int NUM_SNAP  = 8;
    localparam int NUM_TESTS = 1 + 2 + NUM_RAND + 1 + NUM_SNAP;
    localparam int ACK_WAIT  = 20;  // cycles an access may wait for ack
    localparam int EXP_READS = 1 + 2 + NUM_RAND + 2 + 2 * NUM_SNAP;

    logic             clk;
    logic             arst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [WB_AW-1:0] wb_adr;
    logic [WB_DW-1:0] wb_dat_w;
    logic [WB_DW-1:0] wb_dat_r;
    logic             wb_ack;

    logic [CLASS_W-1:0]       exp_class;  // class of the sample in flight or last latched
    int                       n_result_checks = 0;
    integer                   seed;
    logic [N_FEAT*FEAT_W-1:0] feats;
    logic [N_FEAT*FEAT_W-1:0] next_feats;
    logic [WB_DW-1:0]         rdata;

    hartnn_wb_top #(
        .N(N_FEAT),
        .B(FEAT_W),
        .M(N_HID),
        .C(N_CLASS)
    ) dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("TEST FAILED");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic check_class(input string what, input logic [CLASS_W-1:0] got,
                               input logic [CLASS_W-1:0] exp);
        if (got !== exp) fail_now($sformatf("mismatch %s: got %h, expected %h", what, got, exp));
    endtask

    // status fields as {done, busy}
    task automatic check_status(input string what, input logic [1:0] got,
                                input logic [1:0] exp);
        if (got !== exp) fail_now($sformatf("mismatch %s: got %h, expected %h", what, got, exp));
    endtask

    task automatic wait_ack(output logic [WB_DW-1:0] data);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ACK_WAIT) fail_now("the DUT never acknowledged a bus access");
        end while (!wb_ack);
        data = wb_dat_r;
    endtask

    task automatic wb_access(input logic we, input reg_addr_e adr,
                             input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        wait_ack(data);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [WB_DW-1:0] wdata);
        logic [WB_DW-1:0] unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [WB_DW-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic write_features(input logic [N_FEAT*FEAT_W-1:0] f);
        wb_write(REG_FEAT_LO, f[WB_DW-1:0]);
        wb_write(REG_FEAT_HI, WB_DW'(f[N_FEAT*FEAT_W-1:WB_DW]));
    endtask

    task automatic start_class(input logic [N_FEAT*FEAT_W-1:0] f);
        exp_class <= ref_class(f);
        wb_write(REG_CTRL, 32'h1);
    endtask

    task automatic classify(input logic [N_FEAT*FEAT_W-1:0] f);
        logic [WB_DW-1:0] data;
        write_features(f);
        start_class(f);
        wb_read(REG_RESULT, data);  // issued right after the start
    endtask

    // the low feature word goes out back to back with the start and lands while busy
    task automatic start_then_write(input logic [N_FEAT*FEAT_W-1:0] f,
                                    input logic [WB_DW-1:0] lo_word);
        logic [WB_DW-1:0] data;
        exp_class <= ref_class(f);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= REG_CTRL;
        wb_dat_w <= 32'h1;
        wait_ack(data);
        wb_adr   <= REG_FEAT_LO;
        wb_dat_w <= lo_word;
        wait_ack(data);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    function automatic logic [N_FEAT*FEAT_W-1:0] rand_feats();
        logic [N_FEAT*FEAT_W-1:0] v;
        v = '0;
        for (int k = 0; k < N_FEAT; k++) begin
            v[k*FEAT_W +: FEAT_W] = FEAT_W'($random(seed));
        end
        return v;
    endfunction

    // every result read is compared with the class of the last started sample
    always @(posedge clk) begin
        if (arst_n && wb_ack && !wb_we && wb_adr == REG_RESULT) begin
            check_class("result wb_dat_r", wb_dat_r[CLASS_W-1:0], exp_class);
            n_result_checks++;
        end
        if (arst_n && wb_ack && wb_we && wb_adr == REG_CTRL && wb_dat_w[0]) begin
            // done has dropped and busy is up by the start ack
            check_status("status {dut0.u_ctrl.done_q, busy} at start",
                         {dut0.u_ctrl.done_q, dut0.u_ctrl.busy}, 2'b01);
        end
    end

    initial begin
        repeat (NUM_TESTS * 40 + 100) @(posedge clk);
        fail_now("watchdog timeout, the test sequence did not finish in time");
    end

    initial begin
        seed = 32'h3a86_bdcf;
        arst_n    <= 1'b0;
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        wb_we     <= 1'b0;
        wb_adr    <= '0;
        wb_dat_w  <= '0;
        exp_class <= '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        wb_read(REG_STATUS, rdata);
        check_status("status wb_dat_r after reset", rdata[1:0], 2'b00);
        wb_read(REG_RESULT, rdata);

        classify('0);
        classify({N_FEAT{4'hF}});

        for (int i = 0; i < NUM_RAND; i++) begin
            classify(rand_feats());
        end

        feats = rand_feats();
        write_features(feats);
        start_class(feats);
        wb_read(REG_STATUS, rdata);
        if (rdata[1:0] != 2'b01 && rdata[1:0] != 2'b10) begin
            fail_now($sformatf("mismatch status wb_dat_r after start: got %h, expected 1 or 2",
                               rdata[1:0]));
        end
        wb_read(REG_RESULT, rdata);
        wb_read(REG_STATUS, rdata);
        check_status("status wb_dat_r after result read", rdata[1:0], 2'b10);
        start_class(feats);  // done drops again, checked at the start ack
        wb_read(REG_RESULT, rdata);

        for (int i = 0; i < NUM_SNAP; i++) begin
            feats = rand_feats();
            next_feats = rand_feats();
            write_features(feats);
            start_then_write(feats, next_feats[WB_DW-1:0]);
            wb_write(REG_FEAT_HI, WB_DW'(next_feats[N_FEAT*FEAT_W-1:WB_DW]));
            wb_read(REG_RESULT, rdata);  // still the snapshot's class
            start_class(next_feats);
            wb_read(REG_RESULT, rdata);
        end

        repeat (2) @(posedge clk);
        if (n_result_checks != EXP_READS) begin
            fail_now($sformatf("only %0d of %0d result reads were checked",
                               n_result_checks, EXP_READS));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* hartnn_wb_top.f */
+incdir+sim
hw/hartnn_pkg.sv
hw/argmax.sv
hw/feature_bank.sv
hw/hartnn.sv
hw/hartnn_ctrl.sv
hw/hartnn_wb_top.sv
sim/tb_hartnn_wb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and judges the run from its log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_hartnn_wb -f hartnn_wb_top.f \
    > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_hartnn_wb > "$LOG" 2>&1

grep -q "TEST FAILED" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "simulation ended without a result, see $LOG"; exit 1; }
echo "simulation passed"
